//--- files.f
verilog/dmem_pkg.sv
verilog/dmem_decode.sv
verilog/dmem_ram.sv
verilog/dmem_mmio.sv
verilog/dmem_result.sv
verilog/dmem_top.sv
verif/dmem_props.sv
verif/dmem_tb.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module dmem_tb -f files.f -o dmem_sim \
	|| { echo "Build failed"; exit 1; }
out="$(./obj_dir/dmem_sim 2>&1)"
echo "$out"
echo "$out" | grep -qxF "=== PASS ===" && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

//--- verif/dmem_tb.sv
`timescale 1ns/1ps

module dmem_tb;
	import dmem_pkg::*;

	localparam int RAM_AW     = 10;
	localparam int n_trans    = 1000;        // Per port
	localparam int max_cycles = 3 * n_trans; // Ports run side by side

	logic        clkrst_core_clk;
	logic        clkrst_core_rst_n;
	wb_req_t     req0;
	wb_req_t     req1;
	wb_rsp_t     rsp0;
	wb_rsp_t     rsp1;
	logic [31:0] meminput;
	logic [31:0] memoutput;

	logic [31:0] lfsr;
	int          cycles;
	int          issued [2];
	int          done [2];

	// Reference model
	logic [31:0] ram_model [0:(1 << RAM_AW) - 1];
	logic [3:0]  ram_known [0:(1 << RAM_AW) - 1] = '{default: 4'h0}; // Bytes written so far
	logic [31:0] out_model;
	logic [31:0] count_model;
	logic [31:0] prev_in;
	logic [1:0]  exp_ack;
	logic        exp_read;
	logic [31:0] exp_dat;
	logic [31:0] exp_mask;

	dmem_top #(
		.RAM_AW (RAM_AW)
	) dut (
		.clkrst_core_clk   (clkrst_core_clk),
		.clkrst_core_rst_n (clkrst_core_rst_n),
		.wb_req0           (req0),
		.wb_req1           (req1),
		.meminput          (meminput),
		.wb_rsp0           (rsp0),
		.wb_rsp1           (rsp1),
		.memoutput         (memoutput)
	);

	initial begin
		clkrst_core_clk = 1'b0;
		forever #4 clkrst_core_clk = ~clkrst_core_clk;
	end

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]}; // Taps 32 22 2 1
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [31:0] byte_mask(input logic [3:0] sel);
		return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
	endfunction

	// One granted access, and the response it should produce
	task automatic apply_access(input wb_req_t r);
		logic [28:0]       off;
		logic [RAM_AW-1:0] w;
		logic [31:0]       m;
		off      = r.adr[28:0];
		w        = r.adr[RAM_AW-1:0]; // Upper bits alias
		m        = byte_mask(r.sel);
		exp_read = !r.we;
		exp_mask = '1;
		if (r.adr[29]) begin
			case (off)
				mmio_out_off:   exp_dat = out_model;
				mmio_in_off:    exp_dat = prev_in;
				mmio_count_off: exp_dat = count_model;
				default:        exp_dat = '0;
			endcase
			if (r.we && off == mmio_out_off) begin
				out_model = (out_model & ~m) | (r.dat & m);
			end
		end else begin
			exp_dat  = ram_model[w]; // Old word
			exp_mask = byte_mask(ram_known[w]);
			if (r.we) begin
				ram_model[w] = (ram_model[w] & ~m) | (r.dat & m);
				ram_known[w] = ram_known[w] | r.sel;
			end
		end
		count_model = count_model + 1;
	endtask

	always @(posedge clkrst_core_clk) begin
		logic e0;
		logic e1;
		if (!clkrst_core_rst_n) begin
			exp_ack     = 2'b00;
			out_model   = '0;
			count_model = '0;
		end else begin
			// A port in its ack cycle cannot win
			e0      = req0.cyc && req0.stb && !exp_ack[0];
			e1      = req1.cyc && req1.stb && !exp_ack[1];
			exp_ack = 2'b00;
			if (e0) begin
				apply_access(req0);
				exp_ack[0] = 1'b1;
			end else if (e1) begin
				apply_access(req1);
				exp_ack[1] = 1'b1;
			end
		end
		prev_in = meminput;
	end

	always @(posedge clkrst_core_clk) begin
		cycles = cycles + 1;
		if (cycles >= max_cycles) begin
			$display("Timeout after %0d cycles, transactions still open", cycles);
			$display("=== FAIL ===");
			$fatal(1, "run did not finish in time");
		end
	end

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "first mismatch ends the run");
		end
	endtask

	task automatic verify_response(input logic p, input wb_rsp_t rsp);
		compare_value($sformatf("wb_rsp%0d.ack", p), 32'(rsp.ack), 32'(exp_ack[p]));
		if (!exp_ack[p]) begin
			compare_value($sformatf("wb_rsp%0d.dat", p), rsp.dat, 32'd0);
		end else if (exp_read) begin
			compare_value($sformatf("wb_rsp%0d.dat", p), rsp.dat & exp_mask, exp_dat & exp_mask);
		end
	endtask

	task automatic verify_cycle();
		verify_response(1'b0, rsp0);
		verify_response(1'b1, rsp1);
		compare_value("memoutput", memoutput, out_model);
	endtask

	task automatic drive_master(input logic p, input logic ack, inout wb_req_t r);
		if (r.stb && ack) begin
			r.cyc = 1'b0; // Idle for one cycle after ack
			r.stb = 1'b0;
			done[p]++;
		end else if (!r.stb && issued[p] < n_trans && rand_bits(3) != 0) begin
			r.cyc = 1'b1;
			r.stb = 1'b1;
			r.we  = 1'(rand_bits(1));
			r.sel = 4'(rand_bits(4));
			r.dat = rand_bits(32);
			if (rand_bits(1) != 0) begin
				r.adr = {1'b1, 29'(rand_bits(2))};
				if (r.adr[1:0] == 2'd3) r.adr[12] = 1'b1; // Unmapped offset
			end else begin
				r.adr = 30'(rand_bits(2)); // Few words, many collisions
				case (2'(rand_bits(2)))
					2'd0:    r.adr[RAM_AW] = 1'b1;
					2'd1:    r.adr[28] = 1'b1;
					default: ;
				endcase
			end
			issued[p]++;
		end
	endtask

	initial begin
		lfsr              = 32'h4af3fcd9;
		clkrst_core_rst_n = 1'b0;
		req0              = '0;
		req1              = '0;
		meminput          = '0;
		cycles            = 0;
		issued[0]         = 0;
		issued[1]         = 0;
		done[0]           = 0;
		done[1]           = 0;
		repeat (16) @(posedge clkrst_core_clk);
		@(negedge clkrst_core_clk);
		clkrst_core_rst_n = 1'b1;
		repeat (4) begin // Quiet bus right after reset
			@(negedge clkrst_core_clk);
			verify_cycle();
		end
		while (done[0] < n_trans || done[1] < n_trans) begin
			@(negedge clkrst_core_clk);
			verify_cycle();
			drive_master(1'b0, rsp0.ack, req0);
			drive_master(1'b1, rsp1.ack, req1);
			if (rand_bits(1) != 0) meminput = rand_bits(32);
		end
		$display("=== PASS ===");
		$finish;
	end

endmodule

//--- verif/dmem_props.sv
`timescale 1ns/1ps

module dmem_props (
	input logic              clkrst_core_clk,
	input logic              clkrst_core_rst_n,
	input dmem_pkg::wb_req_t wb_req0,
	input dmem_pkg::wb_req_t wb_req1,
	input dmem_pkg::wb_rsp_t wb_rsp0,
	input dmem_pkg::wb_rsp_t wb_rsp1
);

	// Only one access retires per cycle
	ack_exclusive: assert property (@(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
		!(wb_rsp0.ack && wb_rsp1.ack))
		else $error("both ports acknowledged in the same cycle");

	ack0_single: assert property (@(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
		wb_rsp0.ack |=> !wb_rsp0.ack)
		else $error("port 0 ack held longer than one cycle");
	ack1_single: assert property (@(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
		wb_rsp1.ack |=> !wb_rsp1.ack)
		else $error("port 1 ack held longer than one cycle");

	ack0_after_stb: assert property (@(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
		wb_rsp0.ack |-> $past(wb_req0.cyc && wb_req0.stb))
		else $error("port 0 ack without a request in the cycle before");
	ack1_after_stb: assert property (@(posedge clkrst_core_clk) disable iff (!clkrst_core_rst_n)
		wb_rsp1.ack |-> $past(wb_req1.cyc && wb_req1.stb))
		else $error("port 1 ack without a request in the cycle before");

	ack_quiet_in_reset: assert property (@(posedge clkrst_core_clk)
		!clkrst_core_rst_n |-> (!wb_rsp0.ack && !wb_rsp1.ack))
		else $error("ack seen while reset is asserted");

endmodule

bind dmem_top dmem_props props (
	.clkrst_core_clk   (clkrst_core_clk),
	.clkrst_core_rst_n (clkrst_core_rst_n),
	.wb_req0           (wb_req0),
	.wb_req1           (wb_req1),
	.wb_rsp0           (wb_rsp0),
	.wb_rsp1           (wb_rsp1)
);

//--- verilog/dmem_top.sv
`timescale 1ns/1ps

module dmem_top #(
	parameter int RAM_AW = 10
) (
	input  logic              clkrst_core_clk,
	input  logic              clkrst_core_rst_n,
	input  dmem_pkg::wb_req_t wb_req0,
	input  dmem_pkg::wb_req_t wb_req1,
	input  logic [31:0]       meminput,
	output dmem_pkg::wb_rsp_t wb_rsp0,
	output dmem_pkg::wb_rsp_t wb_rsp1,
	output logic [31:0]       memoutput
);
	import dmem_pkg::*;

	dmem_access_t access;     // Combinational, sampled at the edge
	logic         ack0;
	logic         ack1;       // Fed back so decode skips a port in its ack cycle
	logic [31:0]  ram_rdata;
	logic [31:0]  mmio_rdata;

	dmem_decode decode (
		.clkrst_core_clk   (clkrst_core_clk),
		.clkrst_core_rst_n (clkrst_core_rst_n),
		.wb_req0           (wb_req0),
		.wb_req1           (wb_req1),
		.ack0              (ack0),
		.ack1              (ack1),
		.access            (access)
	);

	dmem_ram #(
		.RAM_AW (RAM_AW)
	) ram (
		.clkrst_core_clk (clkrst_core_clk),
		.access          (access),
		.rdata           (ram_rdata)
	);

	dmem_mmio mmio (
		.clkrst_core_clk   (clkrst_core_clk),
		.clkrst_core_rst_n (clkrst_core_rst_n),
		.access            (access),
		.meminput          (meminput),
		.rdata             (mmio_rdata),
		.memoutput         (memoutput)
	);

	dmem_result result (
		.clkrst_core_clk   (clkrst_core_clk),
		.clkrst_core_rst_n (clkrst_core_rst_n),
		.access            (access),
		.ram_rdata         (ram_rdata),
		.mmio_rdata        (mmio_rdata),
		.wb_rsp0           (wb_rsp0),
		.wb_rsp1           (wb_rsp1),
		.ack0              (ack0),
		.ack1              (ack1)
	);

endmodule

//--- verilog/dmem_result.sv
`timescale 1ns/1ps

module dmem_result (
	input  logic                   clkrst_core_clk,
	input  logic                   clkrst_core_rst_n,
	input  dmem_pkg::dmem_access_t access,
	input  logic [31:0]            ram_rdata,
	input  logic [31:0]            mmio_rdata,
	output dmem_pkg::wb_rsp_t      wb_rsp0,
	output dmem_pkg::wb_rsp_t      wb_rsp1,
	output logic                   ack0,
	output logic                   ack1
);
	import dmem_pkg::*;

	logic         valid_q;
	logic         port_q;
	dmem_region_t region_q;
	logic [31:0]  rd;

	always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
		if (!clkrst_core_rst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= access.valid;
		end
	end

	// Only meaningful while valid_q is set
	always_ff @(posedge clkrst_core_clk) begin
		port_q   <= access.port;
		region_q <= access.region;
	end

	assign rd   = (region_q == region_mmio) ? mmio_rdata : ram_rdata;
	assign ack0 = valid_q & ~port_q;
	assign ack1 = valid_q & port_q;

	// The port without an ack sees zero data
	assign wb_rsp0.ack = ack0;
	assign wb_rsp0.dat = ack0 ? rd : 32'd0;
	assign wb_rsp1.ack = ack1;
	assign wb_rsp1.dat = ack1 ? rd : 32'd0;

endmodule

//--- verilog/dmem_mmio.sv
`timescale 1ns/1ps

module dmem_mmio (
	input  logic                   clkrst_core_clk,
	input  logic                   clkrst_core_rst_n,
	input  dmem_pkg::dmem_access_t access,
	input  logic [31:0]            meminput,
	output logic [31:0]            rdata,
	output logic [31:0]            memoutput
);
	import dmem_pkg::*;

	logic [31:0] out_q;
	logic [31:0] in_q;   // One cycle behind the pins
	logic [31:0] count_q;
	logic [28:0] off;
	logic        hit;

	assign off       = access.adr[28:0];
	assign hit       = access.valid && (access.region == region_mmio);
	assign memoutput = out_q;

	always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
		if (!clkrst_core_rst_n) begin
			out_q   <= '0;
			count_q <= '0;
		end else begin
			if (access.valid) begin
				count_q <= count_q + 32'd1; // RAM and MMIO both count
			end
			// Only the output word takes writes
			if (hit && access.we && (off == mmio_out_off)) begin
				for (int b = 0; b < 4; b++) begin
					if (access.sel[b]) begin
						out_q[8*b +: 8] <= access.dat[8*b +: 8];
					end
				end
			end
		end
	end

	always_ff @(posedge clkrst_core_clk) begin
		in_q <= meminput;
	end

	// Register values from before the edge
	always_ff @(posedge clkrst_core_clk) begin
		if (hit && !access.we) begin
			case (off)
				mmio_out_off:   rdata <= out_q;
				mmio_in_off:    rdata <= in_q;
				mmio_count_off: rdata <= count_q;
				default:        rdata <= '0; // Unmapped offsets
			endcase
		end
	end

endmodule

//--- verilog/dmem_ram.sv
`timescale 1ns/1ps

module dmem_ram #(
	parameter int RAM_AW = 10
) (
	input  logic                   clkrst_core_clk,
	input  dmem_pkg::dmem_access_t access,
	output logic [31:0]            rdata
);
	import dmem_pkg::*;

	logic [31:0]       mem [0:(1 << RAM_AW) - 1];
	logic [RAM_AW-1:0] word_adr;
	logic              hit;

	// High address bits are dropped, so large addresses alias low words
	assign word_adr = access.adr[RAM_AW-1:0];
	assign hit      = access.valid && (access.region == region_ram);

	// Old word is captured before the byte writes land
	always_ff @(posedge clkrst_core_clk) begin
		if (hit) begin
			rdata <= mem[word_adr];
		end
	end

	always_ff @(posedge clkrst_core_clk) begin
		if (hit && access.we) begin
			for (int b = 0; b < 4; b++) begin
				if (access.sel[b]) begin
					mem[word_adr][8*b +: 8] <= access.dat[8*b +: 8];
				end
			end
		end
	end

endmodule

//--- verilog/dmem_decode.sv
`timescale 1ns/1ps

module dmem_decode (
	input  logic                   clkrst_core_clk,
	input  logic                   clkrst_core_rst_n,
	input  dmem_pkg::wb_req_t      wb_req0,
	input  dmem_pkg::wb_req_t      wb_req1,
	input  logic                   ack0,
	input  logic                   ack1,
	output dmem_pkg::dmem_access_t access
);
	import dmem_pkg::*;

	logic    issue_en;
	logic    elig0;
	logic    elig1;
	logic    win_port;
	wb_req_t win;

	// Nothing is issued until the first edge after reset is released,
	// so the access valid bit is low all through reset
	always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
		if (!clkrst_core_rst_n) begin
			issue_en <= 1'b0;
		end else begin
			issue_en <= 1'b1;
		end
	end

	// A port in its ack cycle still holds stb, so it sits this one out
	assign elig0 = wb_req0.cyc & wb_req0.stb & ~ack0;
	assign elig1 = wb_req1.cyc & wb_req1.stb & ~ack1;

	// Fixed priority, port 0 wins a tie
	assign win_port = ~elig0;
	assign win      = win_port ? wb_req1 : wb_req0;

	always_comb begin
		access.valid  = issue_en & (elig0 | elig1);
		access.port   = win_port;
		access.region = win.adr[29] ? region_mmio : region_ram; // Bit 29 picks MMIO
		access.we     = win.we;
		access.sel    = win.sel;
		access.adr    = win.adr;
		access.dat    = win.dat;
	end

endmodule

//--- verilog/dmem_pkg.sv
package dmem_pkg;

	// Wishbone classic request from one data port
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [3:0]  sel;
		logic [29:0] adr; // Word address
		logic [31:0] dat;
	} wb_req_t;

	// Response back to one data port
	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} wb_rsp_t;

	// Selected by adr bit 29
	typedef enum logic {
		region_ram  = 1'b0,
		region_mmio = 1'b1
	} dmem_region_t;

	// One access per cycle, issued by decode
	typedef struct packed {
		logic         valid;
		logic         port;   // 0 or 1, the granted port
		dmem_region_t region;
		logic         we;
		logic [3:0]   sel;
		logic [29:0]  adr;
		logic [31:0]  dat;
	} dmem_access_t;

	// MMIO word offsets, taken from adr[28:0]
	localparam logic [28:0] mmio_out_off   = 29'd0;
	localparam logic [28:0] mmio_in_off    = 29'd1;
	localparam logic [28:0] mmio_count_off = 29'd2;

endpackage
